// File: lsu_pipe.f
design/lsu_pkg.sv
design/stage_if.sv
design/data_ram.sv
design/agen_stage.sv
design/mem_stage.sv
design/wb_stage.sv
design/lsu_top.sv
tb/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu_pipe

sources:
  - design/lsu_pkg.sv
  - design/stage_if.sv
  - design/data_ram.sv
  - design/agen_stage.sv
  - design/mem_stage.sv
  - design/wb_stage.sv
  - design/lsu_top.sv
  - target: simulation
    files:
      - tb/lsu_tb.sv

// File: tb/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

  localparam int addr_w   = 10;
  localparam int max_wait = 20;

  logic                      clk;
  logic                      reset;
  logic                      hold;
  logic                      issue_valid;
  lsu_pkg::op_t              op;
  logic [lsu_pkg::xlen-1:0]  rs1_data;
  logic [lsu_pkg::xlen-1:0]  imm;
  logic [lsu_pkg::reg_w-1:0] rd;
  logic [lsu_pkg::reg_w-1:0] rs2;
  logic [lsu_pkg::xlen-1:0]  rs2_data;
  logic [2:0]                width;
  logic                      rf_we;
  logic [lsu_pkg::reg_w-1:0] rf_addr;
  logic [lsu_pkg::xlen-1:0]  rf_data;

  // Byte image of the data RAM with one entry per byte address
  logic [7:0] ref_mem [4 * (2 ** addr_w)];

  integer seed;
  int     errors;
  int     test_errors;
  int     tests_run;
  int     tests_failed;

  lsu_top #(
    .ADDR_W (addr_w)
  ) uut (
    .clk         (clk),
    .reset       (reset),
    .hold        (hold),
    .issue_valid (issue_valid),
    .op          (op),
    .rs1_data    (rs1_data),
    .imm         (imm),
    .rd          (rd),
    .rs2         (rs2),
    .rs2_data    (rs2_data),
    .width       (width),
    .rf_we       (rf_we),
    .rf_addr     (rf_addr),
    .rf_data     (rf_data)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Present one operation for sampling at the following edge
  task automatic drive_op(input lsu_pkg::op_t kind, input logic [31:0] base,
                          input logic [31:0] ofs, input logic [4:0] dst,
                          input logic [4:0] src2, input logic [31:0] src2_data,
                          input logic [2:0] f3);
    @(posedge clk);
    issue_valid <= 1'b1;
    op          <= kind;
    rs1_data    <= base;
    imm         <= ofs;
    rd          <= dst;
    rs2         <= src2;
    rs2_data    <= src2_data;
    width       <= f3;
  endtask

  // Bubble for one cycle
  task automatic drive_idle();
    @(posedge clk);
    issue_valid <= 1'b0;
  endtask

  // Single op then a bubble
  // Returns just after the op's sample edge
  task automatic issue_single(input lsu_pkg::op_t kind, input logic [31:0] base,
                              input logic [31:0] ofs, input logic [4:0] dst,
                              input logic [4:0] src2, input logic [31:0] src2_data,
                              input logic [2:0] f3);
    drive_op(kind, base, ofs, dst, src2, src2_data, f3);
    drive_idle();
  endtask

  ////////////////////
  // Reference memory
  ////////////////////

  // Lanes follow the byte-enable table
  // Data stays on its own lanes
  function automatic void ref_store(input logic [31:0] addr, input logic [31:0] data,
                                    input logic [2:0] f3);
    logic [3:0] be;
    int         word_base;
    be = 4'b1111;
    if (f3 == lsu_pkg::f3_b) begin
      be = 4'b0001 << addr[1:0];
    end else if (f3 == lsu_pkg::f3_h) begin
      // Offset 3 wraps the upper lane back to lane 0
      be = (4'b0011 << addr[1:0]) | ((addr[1:0] == 2'd3) ? 4'b0001 : 4'b0000);
    end
    word_base = {addr[11:2], 2'b00};
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        ref_mem[word_base + i] = data[8*i +: 8];
      end
    end
  endfunction

  // Extension from the low lanes of the addressed word
  function automatic logic [31:0] ref_load(input logic [31:0] addr, input logic [2:0] f3);
    logic [31:0] word;
    int          b;
    b    = {addr[11:2], 2'b00};
    word = {ref_mem[b + 3], ref_mem[b + 2], ref_mem[b + 1], ref_mem[b]};
    case (f3)
      lsu_pkg::f3_b:  return {{24{word[7]}}, word[7:0]};
      lsu_pkg::f3_h:  return {{16{word[15]}}, word[15:0]};
      lsu_pkg::f3_bu: return {24'h0, word[7:0]};
      lsu_pkg::f3_hu: return {16'h0, word[15:0]};
      default:        return word;
    endcase
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  // Wait for the next write port pulse
  // Latency counts edges from the call
  task automatic check_result(input string what, input logic [4:0] exp_addr,
                              input logic [31:0] exp_data, input int exp_lat);
    int lat;
    bit seen;
    lat  = 0;
    seen = 1'b0;
    while (!seen && lat <= max_wait) begin
      @(negedge clk);
      if (rf_we === 1'b1) seen = 1'b1;
      else lat++;
    end
    assert (seen) else begin
      $display("timeout: %s never wrote the register file within %0d cycles", what, max_wait);
      errors++;
    end
    if (seen) begin
      assert (lat == exp_lat) else begin
        $display("ERR rf_we latency (%s) exp %h got %h", what, exp_lat, lat);
        errors++;
      end
      assert (rf_addr === exp_addr) else begin
        $display("ERR rf_addr (%s) exp %h got %h", what, exp_addr, rf_addr);
        errors++;
      end
      assert (rf_data === exp_data) else begin
        $display("ERR rf_data (%s) exp %h got %h", what, exp_data, rf_data);
        errors++;
      end
    end
  endtask

  // No write port pulse for a number of cycles
  task automatic expect_quiet(input string what, input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      assert (rf_we === 1'b0) else begin
        $display("ERR rf_we (%s) exp %h got %h", what, 1'b0, rf_we);
        errors++;
      end
    end
  endtask

  // Load into x20 and compare with the reference image
  task automatic load_check(input logic [31:0] addr, input logic [2:0] f3, input string what);
    issue_single(lsu_pkg::op_load, addr, 32'h0, 5'd20, 5'd0, 32'h0, f3);
    check_result(what, 5'd20, ref_load(addr, f3), 2);
  endtask

  task automatic begin_test();
    test_errors = errors;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, errors - test_errors);
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_alu();
    logic [31:0] a;
    logic [31:0] b;
    begin_test();
    a = $random(seed);
    b = $random(seed);
    issue_single(lsu_pkg::op_alu, a, b, 5'd5, 5'd0, 32'h0, lsu_pkg::f3_w);
    check_result("alu to x5", 5'd5, a + b, 2);
    // x0 target retires silently
    issue_single(lsu_pkg::op_alu, b, a, 5'd0, 5'd0, 32'h0, lsu_pkg::f3_w);
    expect_quiet("alu to x0", 6);
    finish_test("alu writeback");
  endtask

  task automatic test_word();
    logic [31:0] addrs [8];
    logic [31:0] data;
    begin_test();
    // Stores go back to back
    for (int i = 0; i < 8; i++) begin
      addrs[i] = $random(seed) & 32'h0000_0ffc;
      data     = $random(seed);
      ref_store(addrs[i], data, lsu_pkg::f3_w);
      drive_op(lsu_pkg::op_store, addrs[i], 32'h0, 5'd0, 5'd0, data, lsu_pkg::f3_w);
    end
    drive_idle();
    for (int i = 0; i < 8; i++) begin
      load_check(addrs[i], lsu_pkg::f3_w, "lw after sw");
    end
    finish_test("word store and load");
  endtask

  task automatic test_subword();
    logic [31:0] base;
    logic [31:0] data;
    begin_test();
    base = $random(seed) & 32'h0000_0ffc;
    data = $random(seed);
    ref_store(base, data, lsu_pkg::f3_w);
    issue_single(lsu_pkg::op_store, base, 32'h0, 5'd0, 5'd0, data, lsu_pkg::f3_w);
    // sb at every lane
    for (int off = 0; off < 4; off++) begin
      data = $random(seed);
      ref_store(base + off, data, lsu_pkg::f3_b);
      issue_single(lsu_pkg::op_store, base, off, 5'd0, 5'd0, data, lsu_pkg::f3_b);
      load_check(base, lsu_pkg::f3_w, "lw after sb");
    end
    // sh at offsets 0 to 2
    for (int off = 0; off < 3; off++) begin
      data = $random(seed);
      ref_store(base + off, data, lsu_pkg::f3_h);
      issue_single(lsu_pkg::op_store, base, off, 5'd0, 5'd0, data, lsu_pkg::f3_h);
      load_check(base, lsu_pkg::f3_w, "lw after sh");
    end
    finish_test("sub-word stores");
  endtask

  task automatic test_ext();
    logic [31:0] base;
    logic [31:0] word;
    begin_test();
    base = $random(seed) & 32'h0000_0ffc;
    for (int pass = 0; pass < 2; pass++) begin
      word = $random(seed);
      // Sign bits of low byte and half set on the first pass and clear on the second
      word = (pass == 0) ? (word | 32'h8000_8080) : (word & 32'h7fff_7f7f);
      ref_store(base, word, lsu_pkg::f3_w);
      issue_single(lsu_pkg::op_store, base, 32'h0, 5'd0, 5'd0, word, lsu_pkg::f3_w);
      load_check(base, lsu_pkg::f3_b, "lb");
      load_check(base, lsu_pkg::f3_bu, "lbu");
      load_check(base, lsu_pkg::f3_h, "lh");
      load_check(base, lsu_pkg::f3_hu, "lhu");
      load_check(base, lsu_pkg::f3_w, "lw");
    end
    finish_test("load extension");
  endtask

  task automatic test_fwd();
    logic [31:0] addr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] stale;
    begin_test();
    addr  = $random(seed) & 32'h0000_0ffc;
    a     = $random(seed);
    b     = $random(seed);
    stale = ~(a + b);
    // ALU result sits in MEM/WB while the store is in EX/MEM
    drive_op(lsu_pkg::op_alu, a, b, 5'd7, 5'd0, 32'h0, lsu_pkg::f3_w);
    drive_op(lsu_pkg::op_store, addr, 32'h0, 5'd0, 5'd7, stale, lsu_pkg::f3_w);
    drive_idle();
    // One edge after the ALU op was sampled
    check_result("alu before sw", 5'd7, a + b, 1);
    ref_store(addr, a + b, lsu_pkg::f3_w);
    load_check(addr, lsu_pkg::f3_w, "forwarded sw");
    // Bubble in between leaves no write to x7 in MEM/WB
    a     = $random(seed);
    stale = ~(a + b);
    drive_op(lsu_pkg::op_alu, a, b, 5'd7, 5'd0, 32'h0, lsu_pkg::f3_w);
    drive_idle();
    drive_op(lsu_pkg::op_store, addr, 32'h0, 5'd0, 5'd7, stale, lsu_pkg::f3_w);
    drive_idle();
    check_result("alu before bubble", 5'd7, a + b, 0);
    ref_store(addr, stale, lsu_pkg::f3_w);
    load_check(addr, lsu_pkg::f3_w, "unforwarded sw");
    finish_test("store forwarding");
  endtask

  task automatic test_hold();
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    logic [31:0] word;
    int          held;
    begin_test();
    held   = 4;
    addr_a = $random(seed) & 32'h0000_0ffc;
    addr_b = addr_a ^ 32'h0000_0040;
    word   = $random(seed);
    ref_store(addr_a, word, lsu_pkg::f3_w);
    issue_single(lsu_pkg::op_store, addr_a, 32'h0, 5'd0, 5'd0, word, lsu_pkg::f3_w);
    word = $random(seed);
    // Load in MEM/WB and a store in EX/MEM when hold rises
    drive_op(lsu_pkg::op_load, addr_a, 32'h0, 5'd9, 5'd0, 32'h0, lsu_pkg::f3_w);
    drive_op(lsu_pkg::op_store, addr_b, 32'h0, 5'd0, 5'd3, word, lsu_pkg::f3_w);
    @(posedge clk);
    issue_valid <= 1'b0;
    hold        <= 1'b1;
    fork
      begin
        repeat (held) @(posedge clk);
        hold <= 1'b0;
      end
      check_result("load across hold", 5'd9, ref_load(addr_a, lsu_pkg::f3_w), held + 1);
    join
    // Exactly one pulse once released
    expect_quiet("after hold", 1);
    ref_store(addr_b, word, lsu_pkg::f3_w);
    load_check(addr_a, lsu_pkg::f3_w, "lw before hold");
    load_check(addr_b, lsu_pkg::f3_w, "lw held store");
    finish_test("hold");
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    seed         = 32'hc523_d59d;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset        = 1'b1;
    hold         = 1'b0;
    issue_valid  = 1'b0;
    op           = lsu_pkg::op_alu;
    rs1_data     = '0;
    imm          = '0;
    rd           = '0;
    rs2          = '0;
    rs2_data     = '0;
    width        = lsu_pkg::f3_w;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    test_alu();
    test_word();
    test_subword();
    test_ext();
    test_fwd();
    test_hold();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: design/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
  parameter int ADDR_W = lsu_pkg::ram_addr_w
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      hold,
  input  logic                      issue_valid,
  input  lsu_pkg::op_t              op,
  input  logic [lsu_pkg::xlen-1:0]  rs1_data,
  input  logic [lsu_pkg::xlen-1:0]  imm,
  input  logic [lsu_pkg::reg_w-1:0] rd,
  input  logic [lsu_pkg::reg_w-1:0] rs2,
  input  logic [lsu_pkg::xlen-1:0]  rs2_data,
  input  logic [2:0]                width,
  output logic                      rf_we,
  output logic [lsu_pkg::reg_w-1:0] rf_addr,
  output logic [lsu_pkg::xlen-1:0]  rf_data
);

  // Pipeline bundles
  stage_if ex_mem ();
  stage_if mem_wb ();

  // Forwarding path from writeback
  logic [lsu_pkg::xlen-1:0]  wb_res;
  logic                      wb_regwrite;
  logic [lsu_pkg::reg_w-1:0] wb_rd;

  // RAM port and extended load word
  logic                      ram_we;
  logic [3:0]                ram_be;
  logic [ADDR_W-1:0]         ram_addr;
  logic [lsu_pkg::xlen-1:0]  ram_din;
  logic [lsu_pkg::xlen-1:0]  ram_dout;
  logic [lsu_pkg::xlen-1:0]  load_data;

  ////////////////////
  // Stages
  ////////////////////

  agen_stage u_agen (
    .clk         (clk),
    .reset       (reset),
    .hold        (hold),
    .issue_valid (issue_valid),
    .op          (op),
    .rs1_data    (rs1_data),
    .imm         (imm),
    .rd          (rd),
    .rs2         (rs2),
    .rs2_data    (rs2_data),
    .width       (width),
    .ex_mem      (ex_mem.send)
  );

  mem_stage #(
    .ADDR_W (ADDR_W)
  ) u_mem (
    .clk         (clk),
    .reset       (reset),
    .hold        (hold),
    .ex_mem      (ex_mem.receive),
    .wb_res      (wb_res),
    .wb_regwrite (wb_regwrite),
    .wb_rd       (wb_rd),
    .ram_dout    (ram_dout),
    .ram_we      (ram_we),
    .ram_be      (ram_be),
    .ram_addr    (ram_addr),
    .ram_din     (ram_din),
    .mem_wb      (mem_wb.send),
    .load_data   (load_data)
  );

  // Data memory
  data_ram #(
    .ADDR_W (ADDR_W)
  ) u_ram (
    .clk  (clk),
    .we   (ram_we),
    .be   (ram_be),
    .addr (ram_addr),
    .din  (ram_din),
    .dout (ram_dout)
  );

  wb_stage u_wb (
    .clk         (clk),
    .reset       (reset),
    .hold        (hold),
    .mem_wb      (mem_wb.receive),
    .load_data   (load_data),
    .wb_res      (wb_res),
    .wb_regwrite (wb_regwrite),
    .wb_rd       (wb_rd),
    .rf_we       (rf_we),
    .rf_addr     (rf_addr),
    .rf_data     (rf_data)
  );

endmodule

// File: design/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      hold,
  stage_if.receive                  mem_wb,
  input  logic [lsu_pkg::xlen-1:0]  load_data,
  output logic [lsu_pkg::xlen-1:0]  wb_res,
  output logic                      wb_regwrite,
  output logic [lsu_pkg::reg_w-1:0] wb_rd,
  output logic                      rf_we,
  output logic [lsu_pkg::reg_w-1:0] rf_addr,
  output logic [lsu_pkg::xlen-1:0]  rf_data
);

  lsu_pkg::wb_sel_t res_sel;

  ////////////////////
  // Result select
  ////////////////////

  // Loads take the extended RAM word
  assign res_sel = mem_wb.memread ? lsu_pkg::wb_mem : lsu_pkg::wb_alu;
  assign wb_res  = (res_sel == lsu_pkg::wb_mem) ? load_data : mem_wb.alures;

  // Also back to the memory stage for store forwarding
  assign wb_regwrite = mem_wb.regwrite;
  assign wb_rd       = mem_wb.rd;

  ////////////////////
  // Register file write port
  ////////////////////

  // Frozen MEM/WB must not retire twice, so no write while held
  always_ff @(posedge clk) begin
    if (reset) begin
      rf_we <= 1'b0;
    end else if (hold) begin
      rf_we <= 1'b0;
    end else begin
      rf_we <= wb_regwrite && (wb_rd != '0);
    end
  end

  // Address and data
  always_ff @(posedge clk) begin
    if (!hold) begin
      rf_addr <= wb_rd;
      rf_data <= wb_res;
    end
  end

endmodule

// File: design/mem_stage.sv
`timescale 1ns/1ps

module mem_stage #(
  parameter int ADDR_W = lsu_pkg::ram_addr_w
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      hold,
  stage_if.receive                  ex_mem,
  input  logic [lsu_pkg::xlen-1:0]  wb_res,
  input  logic                      wb_regwrite,
  input  logic [lsu_pkg::reg_w-1:0] wb_rd,
  input  logic [lsu_pkg::xlen-1:0]  ram_dout,
  output logic                      ram_we,
  output logic [3:0]                ram_be,
  output logic [ADDR_W-1:0]         ram_addr,
  output logic [lsu_pkg::xlen-1:0]  ram_din,
  stage_if.send                     mem_wb,
  output logic [lsu_pkg::xlen-1:0]  load_data
);

  logic                     fwd_hit;
  logic                     held_q;
  logic [lsu_pkg::xlen-1:0] dout_keep;
  logic [lsu_pkg::xlen-1:0] ld_word;

  ////////////////////
  // Byte enables
  ////////////////////

  always_comb begin
    case (ex_mem.store_ctrl)
      lsu_pkg::st_sb: begin
        // One lane picked by the low address bits
        case (ex_mem.alures[1:0])
          2'b00: ram_be = 4'b0001;
          2'b01: ram_be = 4'b0010;
          2'b10: ram_be = 4'b0100;
          2'b11: ram_be = 4'b1000;
        endcase
      end
      lsu_pkg::st_sh: begin
        // Lane pair with offset 3 wrapping to lane 0
        case (ex_mem.alures[1:0])
          2'b00: ram_be = 4'b0011;
          2'b01: ram_be = 4'b0110;
          2'b10: ram_be = 4'b1100;
          2'b11: ram_be = 4'b1001;
        endcase
      end
      // sw and non-stores
      default: ram_be = 4'b1111;
    endcase
  end

  ////////////////////
  // Store data and RAM drive
  ////////////////////

  // Writeback result overrides stale rs2 data
  // x0 never forwards
  assign fwd_hit = ex_mem.memwrite && wb_regwrite && (wb_rd != '0) && (wb_rd == ex_mem.rs2);

  // Store data goes out unshifted on its own lanes
  assign ram_din = fwd_hit ? wb_res : ex_mem.rs2_data;

  // Write lands once on the edge that moves the store on
  assign ram_we = ex_mem.memwrite && !hold;

  // Word address above the two byte bits
  assign ram_addr = ex_mem.alures[ADDR_W+1:2];

  ////////////////////
  // Load extension
  ////////////////////

  // Once held the RAM reads the EX/MEM address again
  // The word for the load in MEM/WB is kept aside meanwhile
  always_ff @(posedge clk) begin
    if (reset) begin
      held_q <= 1'b0;
    end else begin
      held_q <= hold;
    end
  end

  always_ff @(posedge clk) begin
    if (!held_q) begin
      dout_keep <= ram_dout;
    end
  end

  assign ld_word = held_q ? dout_keep : ram_dout;

  // RAM word arrives with the MEM/WB load kind
  // Only the low lanes are used
  always_comb begin
    case (mem_wb.load_ctrl)
      lsu_pkg::ld_lb:  load_data = {{(lsu_pkg::xlen-8){ld_word[7]}}, ld_word[7:0]};
      lsu_pkg::ld_lh:  load_data = {{(lsu_pkg::xlen-16){ld_word[15]}}, ld_word[15:0]};
      lsu_pkg::ld_lw:  load_data = ld_word;
      lsu_pkg::ld_lbu: load_data = {{(lsu_pkg::xlen-8){1'b0}}, ld_word[7:0]};
      lsu_pkg::ld_lhu: load_data = {{(lsu_pkg::xlen-16){1'b0}}, ld_word[15:0]};
      default:         load_data = '0;
    endcase
  end

  ////////////////////
  // MEM/WB register
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb.regwrite  <= 1'b0;
      mem_wb.memread   <= 1'b0;
      mem_wb.memwrite  <= 1'b0;
      mem_wb.load_ctrl <= lsu_pkg::ld_none;
    end else if (!hold) begin
      mem_wb.regwrite  <= ex_mem.regwrite;
      mem_wb.memread   <= ex_mem.memread;
      mem_wb.memwrite  <= ex_mem.memwrite;
      mem_wb.load_ctrl <= ex_mem.load_ctrl;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (!hold) begin
      mem_wb.alures <= ex_mem.alures;
      mem_wb.rd     <= ex_mem.rd;
    end
  end

  // Store fields end here
  assign mem_wb.rs2        = '0;
  assign mem_wb.rs2_data   = '0;
  assign mem_wb.store_ctrl = lsu_pkg::st_none;

  // Decode upstream never marks one op as both load and store
  a_rw_excl: assert property (@(posedge clk) disable iff (reset)
    !(ex_mem.memread && ex_mem.memwrite));

  // Extender select stays one-hot across the stage boundary
  a_ld_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot0(mem_wb.load_ctrl));

endmodule

// File: design/agen_stage.sv
`timescale 1ns/1ps

module agen_stage (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      hold,
  input  logic                      issue_valid,
  input  lsu_pkg::op_t              op,
  input  logic [lsu_pkg::xlen-1:0]  rs1_data,
  input  logic [lsu_pkg::xlen-1:0]  imm,
  input  logic [lsu_pkg::reg_w-1:0] rd,
  input  logic [lsu_pkg::reg_w-1:0] rs2,
  input  logic [lsu_pkg::xlen-1:0]  rs2_data,
  input  logic [2:0]                width,
  stage_if.send                     ex_mem
);

  logic [lsu_pkg::xlen-1:0] eff_addr;
  logic                     dec_regwrite;
  logic                     dec_memread;
  logic                     dec_memwrite;
  lsu_pkg::load_ctrl_t      dec_load;
  lsu_pkg::store_ctrl_t     dec_store;

  // Effective address, doubles as the ALU result
  assign eff_addr = rs1_data + imm;

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    // Bubble unless a valid issue says otherwise
    dec_regwrite = 1'b0;
    dec_memread  = 1'b0;
    dec_memwrite = 1'b0;
    dec_load     = lsu_pkg::ld_none;
    dec_store    = lsu_pkg::st_none;
    if (issue_valid) begin
      case (op)
        lsu_pkg::op_alu: begin
          dec_regwrite = 1'b1;
        end
        lsu_pkg::op_load: begin
          dec_regwrite = 1'b1;
          dec_memread  = 1'b1;
          case (width)
            lsu_pkg::f3_b:  dec_load = lsu_pkg::ld_lb;
            lsu_pkg::f3_h:  dec_load = lsu_pkg::ld_lh;
            lsu_pkg::f3_w:  dec_load = lsu_pkg::ld_lw;
            lsu_pkg::f3_bu: dec_load = lsu_pkg::ld_lbu;
            lsu_pkg::f3_hu: dec_load = lsu_pkg::ld_lhu;
            default:        dec_load = lsu_pkg::ld_none;
          endcase
        end
        lsu_pkg::op_store: begin
          dec_memwrite = 1'b1;
          case (width)
            lsu_pkg::f3_b: dec_store = lsu_pkg::st_sb;
            lsu_pkg::f3_h: dec_store = lsu_pkg::st_sh;
            lsu_pkg::f3_w: dec_store = lsu_pkg::st_sw;
            default:       dec_store = lsu_pkg::st_none;
          endcase
        end
        // Spare op code stays a bubble
        default: dec_regwrite = 1'b0;
      endcase
    end
  end

  ////////////////////
  // EX/MEM register
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.regwrite   <= 1'b0;
      ex_mem.memread    <= 1'b0;
      ex_mem.memwrite   <= 1'b0;
      ex_mem.load_ctrl  <= lsu_pkg::ld_none;
      ex_mem.store_ctrl <= lsu_pkg::st_none;
    end else if (!hold) begin
      ex_mem.regwrite   <= dec_regwrite;
      ex_mem.memread    <= dec_memread;
      ex_mem.memwrite   <= dec_memwrite;
      ex_mem.load_ctrl  <= dec_load;
      ex_mem.store_ctrl <= dec_store;
    end
  end

  // Payload only
  always_ff @(posedge clk) begin
    if (!hold) begin
      ex_mem.alures   <= eff_addr;
      ex_mem.rd       <= rd;
      ex_mem.rs2      <= rs2;
      ex_mem.rs2_data <= rs2_data;
    end
  end

  // A load in EX/MEM always carries a load kind for the extender downstream
  a_load_kind: assert property (@(posedge clk) disable iff (reset)
    ex_mem.memread |-> (ex_mem.load_ctrl != lsu_pkg::ld_none));

endmodule

// File: design/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
  parameter int ADDR_W = lsu_pkg::ram_addr_w
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [3:0]               be,
  input  logic [ADDR_W-1:0]        addr,
  input  logic [lsu_pkg::xlen-1:0] din,
  output logic [lsu_pkg::xlen-1:0] dout
);

  localparam int depth = 2 ** ADDR_W;

  // Word array, byte lanes written one by one
  logic [lsu_pkg::xlen-1:0] mem [depth];

  ////////////////////
  // Write port
  ////////////////////

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      // Only the enabled lanes change
      if (we && be[i]) begin
        mem[addr][8*i +: 8] <= din[8*i +: 8];
      end
    end
  end

  ////////////////////
  // Read port
  ////////////////////

  // Registered every cycle, old word on a same-address write
  always_ff @(posedge clk) begin
    dout <= mem[addr];
  end

endmodule

// File: design/stage_if.sv
`timescale 1ns/1ps

// One pipeline register bundle between two stages
interface stage_if;

  // Payload
  logic [lsu_pkg::xlen-1:0]  alures;
  logic [lsu_pkg::reg_w-1:0] rd;
  logic [lsu_pkg::reg_w-1:0] rs2;
  logic [lsu_pkg::xlen-1:0]  rs2_data;

  // Control strobes
  logic                      regwrite;
  logic                      memread;
  logic                      memwrite;
  lsu_pkg::load_ctrl_t       load_ctrl;
  lsu_pkg::store_ctrl_t      store_ctrl;

  // Stage that owns the register
  modport send (
    output alures,
    output rd,
    output rs2,
    output rs2_data,
    output regwrite,
    output memread,
    output memwrite,
    output load_ctrl,
    output store_ctrl
  );

  // Stage that consumes it
  modport receive (
    input alures,
    input rd,
    input rs2,
    input rs2_data,
    input regwrite,
    input memread,
    input memwrite,
    input load_ctrl,
    input store_ctrl
  );

endinterface

// File: design/lsu_pkg.sv
package lsu_pkg;

  // Data and address width
  localparam int xlen = 32;

  // Register index width
  localparam int reg_w = 5;

  // Default RAM depth as a word address width, 1024 words
  localparam int ram_addr_w = 10;

  ////////////////////
  // Operation kinds
  ////////////////////

  typedef enum logic [1:0] {
    op_alu   = 2'b00,
    op_load  = 2'b01,
    op_store = 2'b10
  } op_t;

  // Width codes on the issue port, funct3 style
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;
  localparam logic [2:0] f3_hu = 3'b101;

  ////////////////////
  // Load and store control
  ////////////////////

  // One-hot load kind, bit 0 is lb up to bit 4 for lhu
  typedef enum logic [4:0] {
    ld_none = 5'b00000,
    ld_lb   = 5'b00001,
    ld_lh   = 5'b00010,
    ld_lw   = 5'b00100,
    ld_lbu  = 5'b01000,
    ld_lhu  = 5'b10000
  } load_ctrl_t;

  // Store width, zero when not a store
  typedef enum logic [2:0] {
    st_none = 3'b000,
    st_sb   = 3'b001,
    st_sh   = 3'b010,
    st_sw   = 3'b100
  } store_ctrl_t;

  // Writeback result source
  typedef enum logic {
    wb_alu = 1'b0,
    wb_mem = 1'b1
  } wb_sel_t;

endpackage
